// ==== flist.f ====
+incdir+verilog
verilog/decode_pkg.sv
verilog/instr_decoder.sv
verilog/register_file.sv
verilog/branch_agu.sv
verilog/issue_control.sv
verilog/hazard_timer.sv
verilog/decode_stage.sv
verilog/decode_unit.sv
dv/tb_clock_gen.sv
dv/decode_tb.sv

// ==== dv/decode_patterns.txt ====
// 1 writeback: reg value hold_with_next, padded with zeros to 16 words
// 2 instr: pc instr, expected pc class rd wren rs1 rs2 imm jump target addr exc cause tval
1 01 00000010 0 0 0 0 0 0 0 0 0 0 0 0 0
1 02 fffffff0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 03 00001000 0 0 0 0 0 0 0 0 0 0 0 0 0
2 100 00508213 100 0 04 1 00000010 00000000 00000005 0 00000105 00000015 0 0 00000000
2 104 002082b3 104 0 05 1 00000010 fffffff0 00000000 0 00000104 00000010 0 0 00000000
2 108 12345337 108 1 06 1 00000000 00000000 12345000 0 12345108 12345000 0 0 00000000
2 10c 00001397 10c 2 07 1 00000000 00000000 00001000 0 0000110c 00001000 0 0 00000000
1 08 cafe0000 1 0 0 0 0 0 0 0 0 0 0 0 0
2 110 000404b3 110 0 09 1 cafe0000 00000000 00000000 0 00000110 cafe0000 0 0 00000000
2 114 00108463 114 4 00 0 00000010 00000010 00000008 1 0000011c 00000018 0 0 00000000
2 118 0020d863 118 4 00 0 00000010 fffffff0 00000010 1 00000128 00000020 0 0 00000000
2 11c 0020f863 11c 4 00 0 00000010 fffffff0 00000010 0 0000012c 00000020 0 0 00000000
2 120 020000ef 120 3 01 1 00000000 00000000 00000020 1 00000140 00000020 0 0 00000000
2 124 005082e7 124 3 05 1 00000010 00000000 00000005 1 00000014 00000015 0 0 00000000
2 128 00308367 128 3 06 0 00000010 00000000 00000003 0 00000012 00000013 1 0 00000012
2 12c 0081a103 12c 5 02 1 00001000 00000000 00000008 0 00000134 00001008 0 0 00000000
2 130 001105b3 130 0 0b 1 fffffff0 00000010 00000000 0 00000130 fffffff0 0 0 00000000
2 134 00119603 134 5 0c 0 00001000 00000000 00000001 0 00000135 00001001 1 4 00001001
2 138 0011a623 138 6 00 0 00001000 00000010 0000000c 0 00000144 0000100c 0 0 00000000
2 13c 0011a123 13c 6 00 0 00001000 00000010 00000002 0 0000013e 00001002 1 6 00001002
2 140 ffffffff 140 7 00 0 00000000 00000000 00000000 0 00000140 00000000 1 2 ffffffff
2 144 00000073 144 7 00 0 00000000 00000000 00000000 0 00000144 00000000 1 b 00000073
2 148 00100073 148 7 00 0 00000000 00000000 00000000 0 00000148 00000000 1 3 00100073
2 14c 00108013 14c 0 00 0 00000010 00000000 00000001 0 0000014d 00000011 0 0 00000000

// ==== dv/decode_tb.sv ====
`default_nettype none
`include "decode_cfg.svh"

module decode_tb;
    import decode_pkg::*;

    localparam int clock_period   = 40;
    localparam int reset_cycles   = 16;
    localparam int num_lines      = 24;
    localparam int line_words     = 16;
    localparam int watchdog_limit = (reset_cycles + num_lines * 40) * clock_period;

    localparam int f_kind     = 0;  // 1 writeback, 2 instruction
    localparam int f_pc       = 1;
    localparam int f_instr    = 2;
    localparam int f_exp_pc   = 3;
    localparam int f_class    = 4;
    localparam int f_rd       = 5;
    localparam int f_wren     = 6;
    localparam int f_rdata1   = 7;
    localparam int f_rdata2   = 8;
    localparam int f_imm      = 9;
    localparam int f_jump     = 10;
    localparam int f_target   = 11;
    localparam int f_mem_addr = 12;
    localparam int f_exc      = 13;
    localparam int f_cause    = 14;
    localparam int f_tval     = 15;
    localparam int f_wb_reg   = 1;
    localparam int f_wb_data  = 2;
    localparam int f_wb_hold  = 3;  // Keep wb_en up until the next instruction is taken

    logic clock;
    logic reset;
    logic in_valid;
    logic in_ready;
    instr_t in_instr;
    word_t in_pc;
    logic wb_en;
    reg_addr_t wb_addr;
    word_t wb_data;
    logic flush;
    logic out_valid;
    logic out_ready;
    word_t out_pc;
    op_class_t out_class;
    funct_t out_funct;
    reg_addr_t out_rd;
    logic out_wren;
    word_t out_rdata1;
    word_t out_rdata2;
    word_t out_imm;
    logic out_jump;
    word_t out_target;
    word_t out_mem_addr;
    logic out_exception;
    cause_t out_cause;
    word_t out_tval;

    logic [`DECODE_XLEN-1:0] pattern_mem [num_lines * line_words];
    int expect_q[$];
    int issued = 0;
    int received = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int other_errors = 0;
    int field_errors = 0;
    logic [15:0] lfsr = 16'd57;
    logic ready_bit;

    tb_clock_gen #(
        .period(clock_period),
        .reset_cycles(reset_cycles)
    ) clock_gen (
        .clock(clock),
        .reset(reset)
    );

    decode_unit dut0 (
        .clock(clock), .reset(reset),
        .in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr), .in_pc(in_pc),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data), .flush(flush),
        .out_valid(out_valid), .out_ready(out_ready), .out_pc(out_pc),
        .out_class(out_class), .out_funct(out_funct), .out_rd(out_rd),
        .out_wren(out_wren), .out_rdata1(out_rdata1), .out_rdata2(out_rdata2),
        .out_imm(out_imm), .out_jump(out_jump), .out_target(out_target),
        .out_mem_addr(out_mem_addr), .out_exception(out_exception),
        .out_cause(out_cause), .out_tval(out_tval)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    // funct3, with funct7 bit 5 where that bit selects the operation
    function automatic logic [3:0] expected_funct(input logic [31:0] word);
        logic [6:0] opcode;
        logic [2:0] f3;
        opcode = word[6:0];
        f3     = word[14:12];
        if (opcode == 7'b1101111) begin
            return funct_jal;  // jal has no funct3 field
        end else if ((opcode == 7'b0110011) || ((opcode == 7'b0010011) && (f3 == 3'b101))) begin
            return {word[30], f3};
        end else begin
            return {1'b0, f3};
        end
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, want);
            field_errors++;
        end
    endtask

    task automatic expect_low(input string name, input logic value, input string when);
        assert (value === 1'b0) else begin
            $display("Error at %0t: %s is %b, expected 0 %s", $time, name, value, when);
            other_errors++;
        end
    endtask

    task automatic check_record(input int line);
        int base;
        base = line * line_words;
        field_errors = 0;
        check_field("out_pc", out_pc, pattern_mem[base + f_exp_pc]);
        check_field("out_class", out_class, pattern_mem[base + f_class]);
        check_field("out_funct", out_funct, expected_funct(pattern_mem[base + f_instr]));
        check_field("out_rd", out_rd, pattern_mem[base + f_rd]);
        check_field("out_wren", out_wren, pattern_mem[base + f_wren]);
        check_field("out_rdata1", out_rdata1, pattern_mem[base + f_rdata1]);
        check_field("out_rdata2", out_rdata2, pattern_mem[base + f_rdata2]);
        check_field("out_imm", out_imm, pattern_mem[base + f_imm]);
        check_field("out_jump", out_jump, pattern_mem[base + f_jump]);
        check_field("out_target", out_target, pattern_mem[base + f_target]);
        check_field("out_mem_addr", out_mem_addr, pattern_mem[base + f_mem_addr]);
        check_field("out_exception", out_exception, pattern_mem[base + f_exc]);
        check_field("out_cause", out_cause, pattern_mem[base + f_cause]);
        check_field("out_tval", out_tval, pattern_mem[base + f_tval]);
        if (field_errors == 0) begin
            tests_passed++;
            $display("Test %0d, line %0d, pc %h: pass", received + 1, line, out_pc);
        end else begin
            tests_failed++;
            $display("Test %0d, line %0d, pc %h: %0d fields wrong", received + 1, line,
                     out_pc, field_errors);
        end
    endtask

    task automatic write_back(input int line);
        wb_en   = 1'b1;
        wb_addr = pattern_mem[line * line_words + f_wb_reg][4:0];
        wb_data = pattern_mem[line * line_words + f_wb_data];
        if (pattern_mem[line * line_words + f_wb_hold] == '0) begin
            @(negedge clock);
            wb_en = 1'b0;
        end
    endtask

    // Re-offers the trapping word, which must stay blocked until flush
    task automatic hold_for_flush();
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        while ((received < issued) || (waited < 3)) begin
            @(posedge clock);
            expect_low("in_ready", in_ready, "while waiting for flush");
            waited++;
            @(negedge clock);
        end
        flush = 1'b1;
        repeat (2) begin  // Second cycle is already back in run
            @(posedge clock);
            expect_low("in_ready", in_ready, "in a flush cycle");
            @(negedge clock);
        end
        flush    = 1'b0;
        in_valid = 1'b0;
    endtask

    task automatic issue_instr(input int line);
        logic taken;
        taken    = 1'b0;
        in_valid = 1'b1;
        in_pc    = pattern_mem[line * line_words + f_pc];
        in_instr = pattern_mem[line * line_words + f_instr];
        while (!taken) begin
            @(posedge clock);
            taken = in_ready;
        end
        issued++;
        @(negedge clock);
        in_valid = 1'b0;
        wb_en    = 1'b0;
        if (pattern_mem[line * line_words + f_exc] != '0) begin
            hold_for_flush();
        end
    endtask

    task automatic run_patterns();
        for (int i = 0; i < num_lines; i++) begin
            if (pattern_mem[i * line_words + f_kind] == 2) begin
                expect_q.push_back(i);
            end
        end
        wait (reset === 1'b1);
        @(negedge clock);
        for (int i = 0; i < num_lines; i++) begin
            if (pattern_mem[i * line_words + f_kind] == 1) begin
                write_back(i);
            end else begin
                issue_instr(i);
            end
        end
        while (expect_q.size() != 0) begin
            @(negedge clock);
        end
        repeat (4) @(negedge clock);  // Room for a stray extra record
    endtask

    // Random back-pressure, ready about three cycles in four
    always @(negedge clock) begin
        if ($time > 0) begin
            lfsr      = lfsr_step(lfsr);
            ready_bit = lfsr[0];
            lfsr      = lfsr_step(lfsr);
            out_ready = ready_bit | lfsr[0];
            if (reset === 1'b0) begin
                expect_low("in_ready", in_ready, "during reset");
                expect_low("out_valid", out_valid, "during reset");
            end
        end
    end

    always @(posedge clock) begin
        if ((reset === 1'b1) && (out_valid === 1'b1) && (out_ready === 1'b1)) begin
            if (expect_q.size() == 0) begin
                $display("Record with pc %h arrived at %0t after all instructions were matched",
                         out_pc, $time);
                other_errors++;
            end else begin
                check_record(expect_q.pop_front());
            end
            received++;
        end
    end

    initial begin
        #(watchdog_limit);
        $display("Timeout at %0t: the DUT stopped delivering records", $time);
        $display("Something failed");
        $finish;
    end

    initial begin
        in_valid  = 1'b0;
        in_instr  = '0;
        in_pc     = '0;
        wb_en     = 1'b0;
        wb_addr   = '0;
        wb_data   = '0;
        flush     = 1'b0;
        out_ready = 1'b0;
        $readmemh("dv/decode_patterns.txt", pattern_mem);
        if ($isunknown(pattern_mem[num_lines * line_words - 1])) begin
            $display("Pattern file dv/decode_patterns.txt is missing or too short");
            $display("Something failed");
        end else begin
            run_patterns();
            $display("%0d tests passed, %0d tests failed, %0d other errors",
                     tests_passed, tests_failed, other_errors);
            if ((tests_failed == 0) && (other_errors == 0) && (received == issued)) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int period       = 40,
    parameter int reset_cycles = 16
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    initial begin
        reset = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;  // Released on a falling edge
    end

endmodule

`default_nettype wire

// ==== verilog/decode_unit.sv ====
`default_nettype none

module decode_unit (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  decode_pkg::instr_t    in_instr,
    input  decode_pkg::word_t     in_pc,
    input  logic                  wb_en,
    input  decode_pkg::reg_addr_t wb_addr,
    input  decode_pkg::word_t     wb_data,
    input  logic                  flush,
    output logic                  out_valid,
    input  logic                  out_ready,
    output decode_pkg::word_t     out_pc,
    output decode_pkg::op_class_t out_class,
    output decode_pkg::funct_t    out_funct,
    output decode_pkg::reg_addr_t out_rd,
    output logic                  out_wren,
    output decode_pkg::word_t     out_rdata1,
    output decode_pkg::word_t     out_rdata2,
    output decode_pkg::word_t     out_imm,
    output logic                  out_jump,
    output decode_pkg::word_t     out_target,
    output decode_pkg::word_t     out_mem_addr,
    output logic                  out_exception,
    output decode_pkg::cause_t    out_cause,
    output decode_pkg::word_t     out_tval
);
    import decode_pkg::*;

    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    op_class_t op_class;
    funct_t    funct;
    logic      rden1;
    logic      rden2;
    logic      wren;
    logic      illegal;
    logic      ecall;
    logic      ebreak;
    word_t     rdata1;
    word_t     rdata2;
    logic      jump;
    word_t     target;
    word_t     mem_addr;
    logic      misaligned;
    cause_t    mis_cause;
    logic      accept;
    logic      exception;
    logic      timer_start;
    reg_addr_t timer_rd;
    logic      timer_busy;
    reg_addr_t timer_reg;

    instr_decoder u_decoder (
        .instr(in_instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .op_class(op_class), .funct(funct), .rden1(rden1), .rden2(rden2),
        .wren(wren), .illegal(illegal), .ecall(ecall), .ebreak(ebreak)
    );

    register_file u_regfile (
        .clock(clock), .reset(reset), .wb_en(wb_en), .wb_addr(wb_addr),
        .wb_data(wb_data), .raddr1(rs1), .raddr2(rs2),
        .rdata1(rdata1), .rdata2(rdata2)
    );

    branch_agu u_agu (
        .pc(in_pc), .rdata1(rdata1), .rdata2(rdata2), .imm(imm),
        .op_class(op_class), .funct(funct), .jump(jump), .target(target),
        .mem_addr(mem_addr), .misaligned(misaligned), .mis_cause(mis_cause)
    );

    issue_control u_issue (
        .clock(clock), .reset(reset), .in_valid(in_valid), .out_valid(out_valid),
        .out_ready(out_ready), .flush(flush), .op_class(op_class),
        .rden1(rden1), .rden2(rden2), .rs1(rs1), .rs2(rs2), .rd(rd),
        .exception(exception), .timer_busy(timer_busy), .timer_reg(timer_reg),
        .in_ready(in_ready), .accept(accept), .timer_start(timer_start),
        .timer_rd(timer_rd)
    );

    hazard_timer u_timer (
        .clock(clock), .reset(reset), .start(timer_start), .start_rd(timer_rd),
        .clear(flush), .busy(timer_busy), .tracked_rd(timer_reg)
    );

    decode_stage u_stage (
        .clock(clock), .reset(reset), .accept(accept), .flush(flush),
        .out_ready(out_ready), .in_pc(in_pc), .instr(in_instr),
        .op_class(op_class), .funct(funct), .rd(rd), .wren(wren), .imm(imm),
        .illegal(illegal), .ecall(ecall), .ebreak(ebreak),
        .rdata1(rdata1), .rdata2(rdata2), .jump(jump), .target(target),
        .mem_addr(mem_addr), .misaligned(misaligned), .mis_cause(mis_cause),
        .exception(exception), .out_valid(out_valid), .out_pc(out_pc),
        .out_class(out_class), .out_funct(out_funct), .out_rd(out_rd),
        .out_wren(out_wren), .out_rdata1(out_rdata1), .out_rdata2(out_rdata2),
        .out_imm(out_imm), .out_jump(out_jump), .out_target(out_target),
        .out_mem_addr(out_mem_addr), .out_exception(out_exception),
        .out_cause(out_cause), .out_tval(out_tval)
    );

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`default_nettype none

module decode_stage (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  accept,
    input  logic                  flush,
    input  logic                  out_ready,
    input  decode_pkg::word_t     in_pc,
    input  decode_pkg::instr_t    instr,
    input  decode_pkg::op_class_t op_class,
    input  decode_pkg::funct_t    funct,
    input  decode_pkg::reg_addr_t rd,
    input  logic                  wren,
    input  decode_pkg::word_t     imm,
    input  logic                  illegal,
    input  logic                  ecall,
    input  logic                  ebreak,
    input  decode_pkg::word_t     rdata1,
    input  decode_pkg::word_t     rdata2,
    input  logic                  jump,
    input  decode_pkg::word_t     target,
    input  decode_pkg::word_t     mem_addr,
    input  logic                  misaligned,
    input  decode_pkg::cause_t    mis_cause,
    output logic                  exception,
    output logic                  out_valid,
    output decode_pkg::word_t     out_pc,
    output decode_pkg::op_class_t out_class,
    output decode_pkg::funct_t    out_funct,
    output decode_pkg::reg_addr_t out_rd,
    output logic                  out_wren,
    output decode_pkg::word_t     out_rdata1,
    output decode_pkg::word_t     out_rdata2,
    output decode_pkg::word_t     out_imm,
    output logic                  out_jump,
    output decode_pkg::word_t     out_target,
    output decode_pkg::word_t     out_mem_addr,
    output logic                  out_exception,
    output decode_pkg::cause_t    out_cause,
    output decode_pkg::word_t     out_tval
);
    import decode_pkg::*;

    cause_t cause;
    word_t  tval;

    always_comb begin
        exception = 1'b1;
        cause     = cause_illegal;
        tval      = instr;
        if (illegal) begin
            cause = cause_illegal;
        end else if (ebreak) begin
            cause = cause_breakpoint;
        end else if (ecall) begin
            cause = cause_ecall;
        end else if (misaligned) begin
            cause = mis_cause;
            tval  = (mis_cause == cause_misaligned_fetch) ? target : mem_addr;
        end else begin
            exception = 1'b0;
            cause     = '0;
            tval      = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset || flush) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;  // Record taken, nothing new behind it
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            out_pc        <= in_pc;
            out_class     <= op_class;
            out_funct     <= funct;
            out_rd        <= rd;
            out_wren      <= wren && !exception;
            out_rdata1    <= rdata1;
            out_rdata2    <= rdata2;
            out_imm       <= imm;
            out_jump      <= jump && !exception;
            out_target    <= target;
            out_mem_addr  <= mem_addr;
            out_exception <= exception;
            out_cause     <= cause;
            out_tval      <= tval;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/hazard_timer.sv ====
`default_nettype none
`include "decode_cfg.svh"

module hazard_timer (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  decode_pkg::reg_addr_t start_rd,
    input  logic                  clear,
    output logic                  busy,
    output decode_pkg::reg_addr_t tracked_rd
);
    localparam int cnt_w = $clog2(`DECODE_LOAD_LAT + 1);

    logic [cnt_w-1:0] count;

    always_ff @(posedge clock) begin
        if (!reset || clear) begin
            count      <= '0;
            tracked_rd <= '0;
        end else if (start) begin
            count      <= cnt_w'(`DECODE_LOAD_LAT);  // Restart on a newer load
            tracked_rd <= start_rd;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign busy = (count != '0);

endmodule

`default_nettype wire

// ==== verilog/issue_control.sv ====
`default_nettype none

module issue_control (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    input  logic                  out_valid,
    input  logic                  out_ready,
    input  logic                  flush,
    input  decode_pkg::op_class_t op_class,
    input  logic                  rden1,
    input  logic                  rden2,
    input  decode_pkg::reg_addr_t rs1,
    input  decode_pkg::reg_addr_t rs2,
    input  decode_pkg::reg_addr_t rd,
    input  logic                  exception,
    input  logic                  timer_busy,
    input  decode_pkg::reg_addr_t timer_reg,
    output logic                  in_ready,
    output logic                  accept,
    output logic                  timer_start,
    output decode_pkg::reg_addr_t timer_rd
);
    import decode_pkg::*;

    issue_state_t state;
    issue_state_t state_next;
    logic         live;  // Low through reset
    logic         hazard;
    logic         slot_free;

    assign hazard    = timer_busy && ((rden1 && (rs1 == timer_reg)) ||
                                      (rden2 && (rs2 == timer_reg)));
    assign slot_free = !out_valid || out_ready;
    assign in_ready  = live && !flush && slot_free && !hazard && (state != st_trap_wait);
    assign accept    = in_valid && in_ready;
    assign timer_start = accept && !exception && (op_class == class_load) && (rd != '0);
    assign timer_rd    = rd;

    always_comb begin
        state_next = state;
        if (flush) begin
            state_next = st_run;
        end else if (state != st_trap_wait) begin
            if (accept && exception) begin
                state_next = st_trap_wait;
            end else if (in_valid && hazard) begin
                state_next = st_interlock;
            end else begin
                state_next = st_run;  // Also where an interlock ends
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= st_run;
            live  <= 1'b0;
        end else begin
            state <= state_next;
            live  <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/branch_agu.sv ====
`default_nettype none

module branch_agu (
    input  decode_pkg::word_t     pc,
    input  decode_pkg::word_t     rdata1,
    input  decode_pkg::word_t     rdata2,
    input  decode_pkg::word_t     imm,
    input  decode_pkg::op_class_t op_class,
    input  decode_pkg::funct_t    funct,
    output logic                  jump,
    output decode_pkg::word_t     target,
    output decode_pkg::word_t     mem_addr,
    output logic                  misaligned,
    output decode_pkg::cause_t    mis_cause
);
    import decode_pkg::*;

    logic  taken;
    logic  mem_mis;
    logic  is_jalr;
    word_t jalr_sum;

    always_comb begin
        case (funct[2:0])
            3'b000:  taken = (rdata1 == rdata2);
            3'b001:  taken = (rdata1 != rdata2);
            3'b100:  taken = ($signed(rdata1) < $signed(rdata2));
            3'b101:  taken = ($signed(rdata1) >= $signed(rdata2));
            3'b110:  taken = (rdata1 < rdata2);
            3'b111:  taken = (rdata1 >= rdata2);
            default: taken = 1'b0;
        endcase
    end

    assign is_jalr  = (op_class == class_jump) && (funct != funct_jal);
    assign jalr_sum = rdata1 + imm;
    assign jump     = (op_class == class_jump) || ((op_class == class_branch) && taken);
    assign target   = is_jalr ? {jalr_sum[$bits(word_t)-1:1], 1'b0} : pc + imm;
    assign mem_addr = rdata1 + imm;

    always_comb begin
        case (funct[1:0])
            2'b00:   mem_mis = 1'b0;  // Byte
            2'b01:   mem_mis = mem_addr[0];
            default: mem_mis = (mem_addr[1:0] != 2'b00);
        endcase
    end

    always_comb begin
        misaligned = 1'b0;
        mis_cause  = cause_misaligned_fetch;
        if (jump && target[1]) begin
            misaligned = 1'b1;
        end else if ((op_class == class_load) && mem_mis) begin
            misaligned = 1'b1;
            mis_cause  = cause_misaligned_load;
        end else if ((op_class == class_store) && mem_mis) begin
            misaligned = 1'b1;
            mis_cause  = cause_misaligned_store;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/register_file.sv ====
`default_nettype none
`include "decode_cfg.svh"

module register_file (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  wb_en,
    input  decode_pkg::reg_addr_t wb_addr,
    input  decode_pkg::word_t     wb_data,
    input  decode_pkg::reg_addr_t raddr1,
    input  decode_pkg::reg_addr_t raddr2,
    output decode_pkg::word_t     rdata1,
    output decode_pkg::word_t     rdata2
);
    import decode_pkg::*;

    word_t regs [`DECODE_NREGS];
    logic  wr_live;

    assign wr_live = reset && wb_en && (wb_addr != '0);  // x0 never written

    always_ff @(posedge clock) begin
        if (wr_live) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // New data bypassed to a read in the write cycle
    assign rdata1 = (raddr1 == '0)                   ? '0      :
                    (wr_live && (wb_addr == raddr1)) ? wb_data : regs[raddr1];
    assign rdata2 = (raddr2 == '0)                   ? '0      :
                    (wr_live && (wb_addr == raddr2)) ? wb_data : regs[raddr2];

endmodule

`default_nettype wire

// ==== verilog/instr_decoder.sv ====
`default_nettype none

module instr_decoder (
    input  decode_pkg::instr_t    instr,
    output decode_pkg::reg_addr_t rs1,
    output decode_pkg::reg_addr_t rs2,
    output decode_pkg::reg_addr_t rd,
    output decode_pkg::word_t     imm,
    output decode_pkg::op_class_t op_class,
    output decode_pkg::funct_t    funct,
    output logic                  rden1,
    output logic                  rden2,
    output logic                  wren,
    output logic                  illegal,
    output logic                  ecall,
    output logic                  ebreak
);
    import decode_pkg::*;

    opcode_t    opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       writes_rd;
    word_t      imm_i;

    assign opcode = instr[6:0];
    assign f3     = instr[14:12];
    assign f7     = instr[31:25];
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};

    always_comb begin
        op_class  = class_system;
        imm       = '0;
        funct     = {1'b0, f3};
        rden1     = 1'b0;
        rden2     = 1'b0;
        writes_rd = 1'b0;
        illegal   = 1'b0;
        ecall     = 1'b0;
        ebreak    = 1'b0;
        case (opcode)
            opc_lui, opc_auipc: begin
                op_class  = (opcode == opc_lui) ? class_lui : class_auipc;
                imm       = {instr[31:12], 12'b0};
                writes_rd = 1'b1;
            end
            opc_jal: begin
                op_class  = class_jump;
                imm       = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
                funct     = funct_jal;
                writes_rd = 1'b1;
            end
            opc_jalr: begin
                op_class  = class_jump;
                imm       = imm_i;
                rden1     = 1'b1;
                writes_rd = 1'b1;
                illegal   = (f3 != 3'b000);
            end
            opc_branch: begin
                op_class = class_branch;
                imm      = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                rden1    = 1'b1;
                rden2    = 1'b1;
                illegal  = (f3[2:1] == 2'b01);
            end
            opc_load: begin
                op_class  = class_load;
                imm       = imm_i;
                rden1     = 1'b1;
                writes_rd = 1'b1;
                illegal   = (f3 == 3'b011) || (f3[2:1] == 2'b11);
            end
            opc_store: begin
                op_class = class_store;
                imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                rden1    = 1'b1;
                rden2    = 1'b1;
                illegal  = f3[2] || (f3[1:0] == 2'b11);
            end
            opc_op_imm: begin
                op_class  = class_alu;
                imm       = imm_i;
                rden1     = 1'b1;
                writes_rd = 1'b1;
                if (f3 == 3'b001) begin
                    illegal = (f7 != 7'b0000000);
                end else if (f3 == 3'b101) begin
                    funct   = {instr[30], f3};  // srli or srai
                    illegal = (f7 != 7'b0000000) && (f7 != 7'b0100000);
                end
            end
            opc_op: begin
                op_class  = class_alu;
                funct     = {instr[30], f3};
                rden1     = 1'b1;
                rden2     = 1'b1;
                writes_rd = 1'b1;
                illegal   = !((f7 == 7'b0000000) ||
                              ((f7 == 7'b0100000) && ((f3 == 3'b000) || (f3 == 3'b101))));
            end
            opc_system: begin
                ecall   = (instr == 32'h0000_0073);
                ebreak  = (instr == 32'h0010_0073);
                illegal = !(ecall || ebreak);  // No CSR access
            end
            default: illegal = 1'b1;
        endcase
    end

    assign wren = writes_rd && !illegal && (instr[11:7] != '0);
    assign rd   = wren ? instr[11:7] : '0;
    assign rs1  = rden1 ? instr[19:15] : '0;  // Unused ports read x0
    assign rs2  = rden2 ? instr[24:20] : '0;

endmodule

`default_nettype wire

// ==== verilog/decode_pkg.sv ====
`default_nettype none
`include "decode_cfg.svh"

package decode_pkg;

    typedef logic [`DECODE_XLEN-1:0]          word_t;
    typedef logic [31:0]                      instr_t;
    typedef logic [$clog2(`DECODE_NREGS)-1:0] reg_addr_t;
    typedef logic [3:0]                       cause_t;
    typedef logic [2:0]                       op_class_t;
    typedef logic [3:0]                       funct_t;   // {funct7[5], funct3}
    typedef logic [6:0]                       opcode_t;

    localparam op_class_t class_alu    = 3'd0;
    localparam op_class_t class_lui    = 3'd1;
    localparam op_class_t class_auipc  = 3'd2;
    localparam op_class_t class_jump   = 3'd3;
    localparam op_class_t class_branch = 3'd4;
    localparam op_class_t class_load   = 3'd5;
    localparam op_class_t class_store  = 3'd6;
    localparam op_class_t class_system = 3'd7;

    localparam opcode_t opc_lui    = 7'b0110111;
    localparam opcode_t opc_auipc  = 7'b0010111;
    localparam opcode_t opc_jal    = 7'b1101111;
    localparam opcode_t opc_jalr   = 7'b1100111;
    localparam opcode_t opc_branch = 7'b1100011;
    localparam opcode_t opc_load   = 7'b0000011;
    localparam opcode_t opc_store  = 7'b0100011;
    localparam opcode_t opc_op_imm = 7'b0010011;
    localparam opcode_t opc_op     = 7'b0110011;
    localparam opcode_t opc_system = 7'b1110011;

    localparam funct_t funct_jal = 4'b1000;  // Tells jal apart from jalr

    localparam cause_t cause_misaligned_fetch = 4'd0;
    localparam cause_t cause_illegal          = 4'd2;
    localparam cause_t cause_breakpoint       = 4'd3;
    localparam cause_t cause_misaligned_load  = 4'd4;
    localparam cause_t cause_misaligned_store = 4'd6;
    localparam cause_t cause_ecall            = 4'd11;

    typedef enum logic [1:0] {
        st_run,
        st_interlock,
        st_trap_wait
    } issue_state_t;

endpackage

`default_nettype wire

// ==== verilog/decode_cfg.svh ====
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// Data and address width
`define DECODE_XLEN 32

// Architectural registers, x0 included
`define DECODE_NREGS 32

// Cycles a dependent instruction waits behind a load
`define DECODE_LOAD_LAT 2

`endif
